// ==== source/rob_pkg.sv ====
`default_nettype none

package rob_pkg;

  // table geometry
  localparam int rob_depth = 16;
  localparam int rob_idx_w = 4;
  localparam int rob_cnt_w = 5;

  // dram address fields
  localparam int bk_w  = 4;
  localparam int row_w = 14;
  localparam int col_w = 6;

  localparam int data_w = 64;

  // consumer side credit limit
  localparam int out_credit_max = 4;
  // wide enough to hold out_credit_max
  localparam int out_cnt_w      = 3;

  // one bank/row/column triple
  typedef struct packed {
    logic [bk_w-1:0]  bk;
    logic [row_w-1:0] row;
    logic [col_w-1:0] col;
  } rob_addr_t;

  // read request from the requester
  typedef struct packed {
    rob_addr_t addr;
  } rob_req_t;

  // read response from memory, any order
  typedef struct packed {
    rob_addr_t         addr;
    logic [data_w-1:0] data;
  } rob_resp_t;

  // winning table slot with its data
  typedef struct packed {
    logic [rob_idx_w-1:0] idx;
    logic [data_w-1:0]    data;
  } rob_match_t;

  // in-order output beat
  typedef struct packed {
    rob_addr_t         addr;
    logic [data_w-1:0] data;
  } rob_out_t;

endpackage

`default_nettype wire

// ==== source/rob_tag_table.sv ====
`timescale 1ns/1ps
`default_nettype none

module rob_tag_table
  import rob_pkg::*;
(
  input  wire logic                            clk,
  input  wire logic                            rst,
  // request side
  input  wire logic                            i_req_valid,
  input  wire rob_req_t                        i_req,
  // from the match search
  input  wire logic                            i_match_valid,
  input  wire logic [rob_idx_w-1:0]            i_match_idx,
  // from the release unit
  input  wire logic                            i_pop,
  output rob_addr_t [rob_depth-1:0]            o_addrs,
  output logic      [rob_depth-1:0]            o_waiting,
  output logic      [rob_idx_w-1:0]            o_head_idx,
  output rob_addr_t                            o_head_addr,
  output logic                                 o_not_empty,
  output logic                                 o_req_credit
);

  rob_addr_t [rob_depth-1:0] addr_mem;
  logic [rob_depth-1:0]      waiting;
  logic [rob_idx_w-1:0]      head;
  logic [rob_idx_w-1:0]      tail;
  logic [rob_cnt_w-1:0]      count;

  // address slots, written at the tail only
  always_ff @(posedge clk) begin
    if (i_req_valid) begin
      addr_mem[tail] <= i_req.addr;
    end
  end

  // entry waits from its request until a response claims it
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      waiting <= '0;
    end else begin
      if (i_match_valid) begin
        waiting[i_match_idx] <= 1'b0;
      end
      if (i_req_valid) begin
        waiting[tail] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      head  <= '0;
      tail  <= '0;
      count <= '0;
    end else begin
      if (i_req_valid) begin
        tail <= tail + 1'b1;
      end
      if (i_pop) begin
        head <= head + 1'b1;
      end
      case ({i_req_valid, i_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // one credit back per freed slot
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      o_req_credit <= 1'b0;
    end else begin
      o_req_credit <= i_pop;
    end
  end

  assign o_addrs     = addr_mem;
  assign o_waiting   = waiting;
  assign o_head_idx  = head;
  assign o_head_addr = addr_mem[head];
  assign o_not_empty = (count != '0);

  // requester must hold a credit, so a full table sees no request
  a_no_req_when_full: assert property (
    @(posedge clk) disable iff (rst)
    i_req_valid |-> (count != rob_cnt_w'(rob_depth))
  );

  // release may only pop what the table holds
  a_no_pop_when_empty: assert property (
    @(posedge clk) disable iff (rst)
    i_pop |-> (count != '0)
  );

endmodule

`default_nettype wire

// ==== source/rob_match_search.sv ====
`timescale 1ns/1ps
`default_nettype none

module rob_match_search
  import rob_pkg::*;
(
  input  wire logic                            clk,
  input  wire logic                            rst,
  input  wire logic                            i_resp_valid,
  input  wire rob_resp_t                       i_resp,
  input  wire rob_addr_t [rob_depth-1:0]       i_addrs,
  input  wire logic      [rob_depth-1:0]       i_waiting,
  input  wire logic      [rob_idx_w-1:0]       i_head_idx,
  // same-cycle hit, clears the waiting flag
  output logic                                 o_match_valid,
  output logic [rob_idx_w-1:0]                 o_match_idx,
  // registered hit for the data store
  output rob_match_t                           o_match,
  output logic                                 o_orphan
);

  logic [rob_depth-1:0] cand;
  logic [rob_idx_w-1:0] scan_idx;
  logic [rob_idx_w-1:0] pick;
  logic                 found;

  // every waiting slot holding the response address
  always_comb begin
    for (int i = 0; i < rob_depth; i++) begin
      cand[i] = i_waiting[i] && (i_addrs[i] == i_resp.addr);
    end
  end

  // walk forward from the head, first hit is the oldest request
  always_comb begin
    found    = 1'b0;
    pick     = i_head_idx;
    scan_idx = i_head_idx;
    for (int k = 0; k < rob_depth; k++) begin
      scan_idx = i_head_idx + rob_idx_w'(k);
      if (!found && cand[scan_idx]) begin
        found = 1'b1;
        pick  = scan_idx;
      end
    end
  end

  assign o_match_valid = i_resp_valid && found;
  assign o_match_idx   = pick;

  always_ff @(posedge clk) begin
    if (o_match_valid) begin
      o_match.idx  <= pick;
      o_match.data <= i_resp.data;
    end
  end

  // nothing waiting for this address, response is dropped
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      o_orphan <= 1'b0;
    end else begin
      o_orphan <= i_resp_valid && !found;
    end
  end

endmodule

`default_nettype wire

// ==== source/rob_data_store.sv ====
`timescale 1ns/1ps
`default_nettype none

module rob_data_store
  import rob_pkg::*;
(
  input  wire logic                            clk,
  input  wire logic                            rst,
  // hit seen by the search this cycle
  input  wire logic                            i_match_valid,
  // registered hit, one cycle behind i_match_valid
  input  wire rob_match_t                      i_match,
  input  wire logic [rob_idx_w-1:0]            i_head_idx,
  input  wire logic                            i_pop,
  output logic [data_w-1:0]                    o_head_data,
  output logic                                 o_head_filled
);

  logic [data_w-1:0]    data_mem [rob_depth];
  logic [rob_depth-1:0] filled;
  logic                 wr_pend;

  // lines the valid up with the registered match
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      wr_pend <= 1'b0;
    end else begin
      wr_pend <= i_match_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (wr_pend) begin
      data_mem[i_match.idx] <= i_match.data;
    end
  end

  // set by a write, cleared when the head leaves
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      filled <= '0;
    end else begin
      if (i_pop) begin
        filled[i_head_idx] <= 1'b0;
      end
      if (wr_pend) begin
        filled[i_match.idx] <= 1'b1;
      end
    end
  end

  assign o_head_data   = data_mem[i_head_idx];
  assign o_head_filled = filled[i_head_idx];

  // waiting flag cleared a cycle earlier, so no slot gets data twice
  a_no_double_fill: assert property (
    @(posedge clk) disable iff (rst)
    wr_pend |-> !filled[i_match.idx]
  );

endmodule

`default_nettype wire

// ==== source/rob_release.sv ====
`timescale 1ns/1ps
`default_nettype none

module rob_release
  import rob_pkg::*;
(
  input  wire logic                            clk,
  input  wire logic                            rst,
  // head state from tag table and data store
  input  wire logic                            i_not_empty,
  input  wire logic                            i_head_filled,
  input  wire rob_addr_t                       i_head_addr,
  input  wire logic [data_w-1:0]               i_head_data,
  // one pulse per credit handed back by the consumer
  input  wire logic                            i_out_credit,
  output logic                                 o_pop,
  output logic                                 o_out_valid,
  output rob_out_t                             o_out
);

  logic [out_cnt_w-1:0] credits;
  logic                 credit_ok;

  assign credit_ok = (credits != '0);
  assign o_pop     = i_not_empty && i_head_filled && credit_ok;

  // consumer credit counter starts full after reset
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      credits <= out_cnt_w'(out_credit_max);
    end else begin
      case ({i_out_credit, o_pop})
        2'b10:   credits <= credits + 1'b1;
        2'b01:   credits <= credits - 1'b1;
        default: credits <= credits;
      endcase
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      o_out_valid <= 1'b0;
    end else begin
      o_out_valid <= o_pop;
    end
  end

  // output beat loaded only on a pop
  always_ff @(posedge clk) begin
    if (o_pop) begin
      o_out.addr <= i_head_addr;
      o_out.data <= i_head_data;
    end
  end

  // consumer returns no more than it was given
  a_credit_limit: assert property (
    @(posedge clk) disable iff (rst)
    credits <= out_cnt_w'(out_credit_max)
  );

endmodule

`default_nettype wire

// ==== source/rob_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module rob_top
  import rob_pkg::*;
(
  input  wire logic        clk,
  input  wire logic        rst,
  // requests, in order, credit based
  input  wire logic        i_req_valid,
  input  wire rob_req_t    i_req,
  // responses, any order, no flow control
  input  wire logic        i_resp_valid,
  input  wire rob_resp_t   i_resp,
  // consumer credit return
  input  wire logic        i_out_credit,
  output logic             o_req_credit,
  output logic             o_resp_orphan,
  output logic             o_out_valid,
  output rob_out_t         o_out
);

  rob_addr_t [rob_depth-1:0] addrs;
  logic [rob_depth-1:0]      waiting;
  logic [rob_idx_w-1:0]      head_idx;
  rob_addr_t                 head_addr;
  logic                      not_empty;
  logic                      match_valid;
  logic [rob_idx_w-1:0]      match_idx;
  rob_match_t                match;
  logic [data_w-1:0]         head_data;
  logic                      head_filled;
  logic                      pop;

  rob_tag_table u_tag_table (
    .clk           (clk),
    .rst           (rst),
    .i_req_valid   (i_req_valid),
    .i_req         (i_req),
    .i_match_valid (match_valid),
    .i_match_idx   (match_idx),
    .i_pop         (pop),
    .o_addrs       (addrs),
    .o_waiting     (waiting),
    .o_head_idx    (head_idx),
    .o_head_addr   (head_addr),
    .o_not_empty   (not_empty),
    .o_req_credit  (o_req_credit)
  );

  rob_match_search u_match_search (
    .clk           (clk),
    .rst           (rst),
    .i_resp_valid  (i_resp_valid),
    .i_resp        (i_resp),
    .i_addrs       (addrs),
    .i_waiting     (waiting),
    .i_head_idx    (head_idx),
    .o_match_valid (match_valid),
    .o_match_idx   (match_idx),
    .o_match       (match),
    .o_orphan      (o_resp_orphan)
  );

  rob_data_store u_data_store (
    .clk           (clk),
    .rst           (rst),
    .i_match_valid (match_valid),
    .i_match       (match),
    .i_head_idx    (head_idx),
    .i_pop         (pop),
    .o_head_data   (head_data),
    .o_head_filled (head_filled)
  );

  rob_release u_release (
    .clk           (clk),
    .rst           (rst),
    .i_not_empty   (not_empty),
    .i_head_filled (head_filled),
    .i_head_addr   (head_addr),
    .i_head_data   (head_data),
    .i_out_credit  (i_out_credit),
    .o_pop         (pop),
    .o_out_valid   (o_out_valid),
    .o_out         (o_out)
  );

endmodule

`default_nettype wire

// ==== verification/rob_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module rob_tb
  import rob_pkg::*;
();

  localparam int          n_req_total  = 35;
  localparam int          n_resp_total = 37;
  localparam int          cycle_limit  = 4 * (n_req_total + n_resp_total) + 200;
  localparam logic [31:0] lfsr_seed    = 32'ha1d521a5;

  logic              clk          = 1'b0;
  logic              rst          = 1'b1;
  logic              i_req_valid  = 1'b0;
  rob_req_t          i_req        = '0;
  logic              i_resp_valid = 1'b0;
  rob_resp_t         i_resp       = '0;
  logic              i_out_credit = 1'b0;
  logic              o_req_credit;
  logic              o_resp_orphan;
  logic              o_out_valid;
  rob_out_t          o_out;

  rob_addr_t         pend_q[$];
  rob_addr_t         issued_q[$];
  rob_resp_t         resp_q[$];
  // reference model with the oldest request first
  rob_addr_t         m_addr[$];
  logic [data_w-1:0] m_data[$];
  logic              m_full[$];
  logic              exp_avail  = 1'b0;
  rob_addr_t         exp_addr   = '0;
  logic [data_w-1:0] exp_data   = '0;
  logic              exp_orphan = 1'b0;
  logic              req_seen   = 1'b0;
  logic              credit_en  = 1'b0;
  logic [31:0]       stim_lfsr  = lfsr_seed;
  logic [31:0]       gap_lfsr   = lfsr_seed;
  int                n_req      = 0;
  int                n_ret      = 0;
  int                n_out      = 0;
  int                n_grant    = 0;
  int                req_cred   = rob_depth;
  int                owed       = 0;
  int                cycles     = 0;
  int                val_errs   = 0;
  int                proto_errs = 0;

  rob_top UUT (.*);

  always #5 clk = ~clk;

  // taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic take_bits(input int n, output logic [63:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      stim_lfsr = lfsr_next(stim_lfsr);
      v = {v[62:0], stim_lfsr[0]};
    end
  endtask

  task automatic queue_requests(input int n);
    rob_addr_t   a;
    logic [63:0] v;
    for (int i = 0; i < n; i++) begin
      take_bits(24, v);
      a = v[23:0];
      // bank 8 and up stays free for orphan responses
      a.bk[3] = 1'b0;
      pend_q.push_back(a);
    end
  endtask

  task automatic answer(input int idx);
    rob_resp_t   r;
    logic [63:0] v;
    take_bits(data_w, v);
    r.addr = issued_q[idx];
    r.data = v;
    resp_q.push_back(r);
  endtask

  task automatic answer_shuffled(input int first, input int n);
    int          order[$];
    int          j;
    int          t;
    logic [63:0] v;
    for (int i = 0; i < n; i++) begin
      order.push_back(first + i);
    end
    for (int i = n - 1; i > 0; i--) begin
      take_bits(8, v);
      j = int'(v[7:0]) % (i + 1);
      t = order[i];
      order[i] = order[j];
      order[j] = t;
    end
    foreach (order[k]) begin
      answer(order[k]);
    end
  endtask

  task automatic wait_issued(input int target);
    while (issued_q.size() < target) @(negedge clk);
  endtask

  task automatic wait_drained();
    while (m_addr.size() != 0 || pend_q.size() != 0 || resp_q.size() != 0 || owed != 0) begin
      @(negedge clk);
    end
    repeat (3) @(negedge clk);
  endtask

  task automatic report_counts();
    $display("closing report: %0d value errors, %0d other errors, %0d outputs, %0d cycles",
             val_errs, proto_errs, n_out, cycles);
  endtask

  // requester spends one credit per request
  always @(posedge clk) begin : requester
    if (rst) begin
      i_req_valid <= 1'b0;
      req_cred = rob_depth;
    end else begin
      if (o_req_credit) begin
        req_cred = req_cred + 1;
      end
      if (pend_q.size() > 0 && req_cred > 0) begin
        i_req_valid <= 1'b1;
        i_req.addr  <= pend_q[0];
        issued_q.push_back(pend_q.pop_front());
        req_cred = req_cred - 1;
      end else begin
        i_req_valid <= 1'b0;
      end
    end
  end

  always @(posedge clk) begin : responder
    if (rst) begin
      i_resp_valid <= 1'b0;
    end else if (resp_q.size() > 0) begin
      i_resp_valid <= 1'b1;
      i_resp       <= resp_q.pop_front();
    end else begin
      i_resp_valid <= 1'b0;
    end
  end

  // consumer hands one credit back per output after a random gap
  always @(posedge clk) begin : consumer
    if (rst) begin
      i_out_credit <= 1'b0;
      owed = 0;
    end else begin
      if (o_out_valid) begin
        owed = owed + 1;
      end
      gap_lfsr = lfsr_next(gap_lfsr);
      if (credit_en && owed > 0 && gap_lfsr[0]) begin
        i_out_credit <= 1'b1;
        owed = owed - 1;
      end else begin
        i_out_credit <= 1'b0;
      end
    end
  end

  always @(posedge clk) begin : model
    int hit;
    hit = -1;
    if (!rst) begin
      if (i_resp_valid) begin
        // oldest request for this address still without data
        for (int i = 0; i < m_addr.size(); i++) begin
          if (hit < 0 && !m_full[i] && m_addr[i] == i_resp.addr) begin
            hit = i;
          end
        end
        if (hit >= 0) begin
          m_full[hit] = 1'b1;
          m_data[hit] = i_resp.data;
        end
      end
      exp_orphan <= i_resp_valid && hit < 0;
      if (o_out_valid && m_addr.size() > 0) begin
        m_addr.delete(0);
        m_data.delete(0);
        m_full.delete(0);
      end
      if (i_req_valid) begin
        m_addr.push_back(i_req.addr);
        m_data.push_back('0);
        m_full.push_back(1'b0);
        req_seen <= 1'b1;
      end
      n_req   <= n_req + int'(i_req_valid);
      n_ret   <= n_ret + int'(o_req_credit);
      n_out   <= n_out + int'(o_out_valid);
      n_grant <= n_grant + int'(i_out_credit);
      if (m_addr.size() > 0) begin
        exp_avail <= m_full[0];
        exp_addr  <= m_addr[0];
        exp_data  <= m_data[0];
      end else begin
        exp_avail <= 1'b0;
      end
    end
  end

  a_quiet_after_reset: assert property (@(posedge clk) disable iff (rst)
    !req_seen |-> !o_out_valid && !o_req_credit && !o_resp_orphan
  ) else begin
    proto_errs++;
    $display("%0t: an output pulsed before the first request", $time);
  end

  a_out_expected: assert property (@(posedge clk) disable iff (rst)
    o_out_valid |-> exp_avail
  ) else begin
    proto_errs++;
    $display("%0t: output released while the oldest request had no data", $time);
  end

  a_out_addr: assert property (@(posedge clk) disable iff (rst)
    o_out_valid |-> o_out.addr == exp_addr
  ) else begin
    val_errs++;
    $display("error %0t: o_out.addr = %h, expected %h",
             $time, $sampled(o_out.addr), $sampled(exp_addr));
  end

  a_out_data: assert property (@(posedge clk) disable iff (rst)
    o_out_valid |-> o_out.data == exp_data
  ) else begin
    val_errs++;
    $display("error %0t: o_out.data = %h, expected %h",
             $time, $sampled(o_out.data), $sampled(exp_data));
  end

  a_orphan: assert property (@(posedge clk) disable iff (rst)
    o_resp_orphan == exp_orphan
  ) else begin
    val_errs++;
    $display("error %0t: o_resp_orphan = %b, expected %b",
             $time, $sampled(o_resp_orphan), $sampled(exp_orphan));
  end

  a_out_window: assert property (@(posedge clk) disable iff (rst)
    n_out <= n_grant + out_credit_max
  ) else begin
    proto_errs++;
    $display("%0t: more outputs than credits granted", $time);
  end

  a_credit_per_output: assert property (@(posedge clk) disable iff (rst)
    o_req_credit == o_out_valid
  ) else begin
    proto_errs++;
    $display("%0t: request credit returned without a freed entry", $time);
  end

  a_req_has_credit: assert property (@(posedge clk) disable iff (rst)
    n_req - n_out <= rob_depth
  ) else begin
    proto_errs++;
    $display("%0t: more requests outstanding than table entries", $time);
  end

  always @(posedge clk) begin : watchdog
    cycles <= cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("timeout: run did not finish within %0d cycles", cycle_limit);
      report_counts();
      $display("ERRORS FOUND");
      $finish;
    end
  end

  initial begin : main
    int          base;
    int          out_mark;
    rob_addr_t   dup;
    rob_resp_t   r;
    logic [63:0] v;
    repeat (2) @(posedge clk);
    rst <= 1'b0;
    repeat (5) @(negedge clk);

    // reverse order responses
    credit_en = 1'b1;
    base = issued_q.size();
    queue_requests(8);
    wait_issued(base + 8);
    for (int i = 7; i >= 0; i--) begin
      answer(base + i);
    end
    wait_drained();

    // three requests to one address
    take_bits(24, v);
    dup = v[23:0];
    dup.bk[3] = 1'b0;
    base = issued_q.size();
    repeat (3) pend_q.push_back(dup);
    wait_issued(base + 3);
    for (int i = 0; i < 3; i++) begin
      take_bits(56, v);
      r.addr = dup;
      r.data = {v[55:0], 8'(i)};
      resp_q.push_back(r);
    end
    wait_drained();

    // consumer holds its credits back
    credit_en = 1'b0;
    out_mark = n_out;
    base = issued_q.size();
    queue_requests(8);
    wait_issued(base + 8);
    answer_shuffled(base, 8);
    repeat (20) @(negedge clk);
    assert (n_out - out_mark == out_credit_max) else begin
      proto_errs++;
      $display("expected exactly %0d outputs without credit return", out_credit_max);
    end
    queue_requests(16);
    wait_issued(base + 20);
    repeat (20) @(negedge clk);
    assert (n_req - n_ret == rob_depth && pend_q.size() == 4) else begin
      proto_errs++;
      $display("table did not fill and stall the requester");
    end
    answer_shuffled(base + 8, 12);
    repeat (20) @(negedge clk);
    credit_en = 1'b1;
    wait_issued(base + 24);
    answer_shuffled(base + 20, 4);
    wait_drained();

    // nothing waits for these
    r.addr.bk  = 4'hf;
    r.addr.row = '0;
    r.addr.col = '0;
    r.data     = '1;
    resp_q.push_back(r);
    r.addr = dup;
    resp_q.push_back(r);
    repeat (6) @(negedge clk);

    assert (m_addr.size() == 0 && n_ret == n_out) else begin
      proto_errs++;
      $display("entries left behind or credits not matching outputs");
    end
    report_counts();
    if (val_errs == 0 && proto_errs == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== filelist.f ====
source/rob_pkg.sv
source/rob_tag_table.sv
source/rob_match_search.sv
source/rob_data_store.sv
source/rob_release.sv
source/rob_top.sv
verification/rob_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the reorder buffer testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f filelist.f --top-module rob_tb -o rob_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/rob_sim)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if grep -qx "NO ERRORS" <<< "$sim_out"; then
  exit 0
fi
exit 1
